// File: source/csr_addr_pkg.sv
package csr_addr_pkg;

    localparam int csr_addr_w = 14;

    ////////////////////////////////////////
    // register addresses

    localparam logic [csr_addr_w-1:0] addr_crmd      = 14'h000;
    localparam logic [csr_addr_w-1:0] addr_prmd      = 14'h001;
    localparam logic [csr_addr_w-1:0] addr_ecfg      = 14'h004;
    localparam logic [csr_addr_w-1:0] addr_estat     = 14'h005;
    localparam logic [csr_addr_w-1:0] addr_era       = 14'h006;
    localparam logic [csr_addr_w-1:0] addr_badv      = 14'h007;
    localparam logic [csr_addr_w-1:0] addr_eentry    = 14'h00c;
    // SAVE0 here, the rest follow at +1
    localparam logic [csr_addr_w-1:0] addr_save_base = 14'h030;

    ////////////////////////////////////////
    // counts and widths

    localparam int num_save   = 4;
    localparam int num_hw_int = 8;
    // 2 software, 8 hardware, 3 unused
    localparam int num_int    = 13;

    // top bit of the exception input carries the subcode
    localparam int ecode_in_w = 7;
    localparam int ecode_w    = ecode_in_w - 1;

endpackage

// File: source/csr_field_pkg.sv
package csr_field_pkg;

    typedef logic [31:0] csr_word_t;
    typedef logic [1:0]  plv_t;
    typedef logic [1:0]  mat_t;

    ////////////////////////////////////////
    // register layouts, msb first

    typedef struct packed {
        logic [22:0] zero;
        mat_t        datm;
        mat_t        datf;
        logic        pg;
        logic        da;
        logic        ie;
        plv_t        plv;
    } crmd_t;

    typedef struct packed {
        logic [28:0] zero;
        logic        pie;
        plv_t        pplv;
    } prmd_t;

    typedef struct packed {
        logic                               zero_hi;
        logic [8:0]                         esubcode;
        logic [csr_addr_pkg::ecode_w-1:0]   ecode;
        logic [15-csr_addr_pkg::num_int:0]  zero_lo;
        logic [csr_addr_pkg::num_int-1:0]   is;
    } estat_t;

    typedef struct packed {
        logic [25:0] va;
        logic [5:0]  zero;
    } eentry_t;

    // one word seen as any of the layouts
    typedef union packed {
        csr_word_t raw;
        crmd_t     crmd;
        prmd_t     prmd;
        estat_t    estat;
        eentry_t   eentry;
    } csr_view_u;

    // direct translation, both accesses uncached
    localparam csr_word_t crmd_reset_val = 32'h0000_0008;

    // bitwise masked merge of a software write
    function automatic csr_word_t merge_word(csr_word_t old, csr_word_t mask, csr_word_t data);
        return (old & ~mask) | (data & mask);
    endfunction

endpackage

// File: source/csr_mode_regs.sv
`timescale 1ns/10ps

module csr_mode_regs (
    input  logic                                clk,
    input  logic                                rstn,
    input  logic                                software_we,
    input  logic [csr_addr_pkg::csr_addr_w-1:0] waddr,
    input  csr_field_pkg::csr_word_t            wmask,
    input  csr_field_pkg::csr_word_t            wdata,
    input  logic                                store_state,
    input  logic                                restore_state,
    output csr_field_pkg::csr_word_t            crmd_word,
    output csr_field_pkg::csr_word_t            prmd_word,
    output csr_field_pkg::plv_t                 plv,
    output logic                                ie,
    output logic [1:0]                          translate_mode,
    output csr_field_pkg::mat_t                 direct_i_mat,
    output csr_field_pkg::mat_t                 direct_d_mat
);

    import csr_addr_pkg::*;
    import csr_field_pkg::*;

    crmd_t     crmd_q;
    prmd_t     prmd_q;
    csr_view_u crmd_wr;
    csr_view_u prmd_wr;
    logic      crmd_sel;
    logic      prmd_sel;

    assign crmd_sel = software_we && (waddr == addr_crmd);
    assign prmd_sel = software_we && (waddr == addr_prmd);

    ////////////////////////////////////////
    // software write images

    always_comb begin
        crmd_wr.raw       = merge_word(crmd_q, wmask, wdata);
        crmd_wr.crmd.zero = '0;
        // illegal pg/da pair keeps the old mode
        if (crmd_wr.crmd.pg == crmd_wr.crmd.da) begin
            crmd_wr.crmd.pg = crmd_q.pg;
            crmd_wr.crmd.da = crmd_q.da;
        end
        prmd_wr.raw       = merge_word(prmd_q, wmask, wdata);
        prmd_wr.prmd.zero = '0;
    end

    ////////////////////////////////////////
    // registers

    always_ff @(posedge clk) begin
        if (!rstn) begin
            crmd_q <= crmd_reset_val;
        end else if (restore_state) begin
            crmd_q.plv <= prmd_q.pplv;
            crmd_q.ie  <= prmd_q.pie;
        end else if (store_state) begin
            // exception entry runs at plv0 with interrupts off
            crmd_q.plv <= '0;
            crmd_q.ie  <= 1'b0;
        end else if (crmd_sel) begin
            crmd_q <= crmd_wr.crmd;
        end
    end

    always_ff @(posedge clk) begin
        if (!rstn) begin
            prmd_q <= '0;
        end else if (store_state) begin
            prmd_q.pplv <= crmd_q.plv;
            prmd_q.pie  <= crmd_q.ie;
        end else if (prmd_sel) begin
            prmd_q <= prmd_wr.prmd;
        end
    end

    assign crmd_word      = crmd_q;
    assign prmd_word      = prmd_q;
    assign plv            = crmd_q.plv;
    assign ie             = crmd_q.ie;
    // 01 direct, 10 paged
    assign translate_mode = {crmd_q.pg, crmd_q.da};
    assign direct_i_mat   = crmd_q.datf;
    assign direct_d_mat   = crmd_q.datm;

endmodule

// File: source/csr_exception_regs.sv
`timescale 1ns/10ps

module csr_exception_regs (
    input  logic                                   clk,
    input  logic                                   rstn,
    input  logic                                   software_we,
    input  logic [csr_addr_pkg::csr_addr_w-1:0]    waddr,
    input  csr_field_pkg::csr_word_t               wmask,
    input  csr_field_pkg::csr_word_t               wdata,
    input  logic                                   ecode_we,
    input  logic [csr_addr_pkg::ecode_in_w-1:0]    ecode_in,
    input  logic                                   era_we,
    input  csr_field_pkg::csr_word_t               era_in,
    input  logic                                   badv_we,
    input  csr_field_pkg::csr_word_t               badv_in,
    input  logic [csr_addr_pkg::num_hw_int-1:0]    hardware_int,
    input  logic                                   ie,
    output csr_field_pkg::csr_word_t               ecfg_word,
    output csr_field_pkg::csr_word_t               estat_word,
    output csr_field_pkg::csr_word_t               era_word,
    output csr_field_pkg::csr_word_t               badv_word,
    output csr_field_pkg::csr_word_t               eentry_word,
    output logic [csr_addr_pkg::ecode_w-1:0]       ecode,
    output csr_field_pkg::csr_word_t               era_out,
    output csr_field_pkg::csr_word_t               eentry,
    output logic                                   has_interrupt_cpu,
    output logic                                   has_interrupt_idle
);

    import csr_addr_pkg::*;
    import csr_field_pkg::*;

    logic [num_int-1:0] ecfg_q;
    logic [1:0]         sw_int_q;
    logic [ecode_w-1:0] ecode_q;
    logic [8:0]         esubcode_q;
    csr_word_t          era_q;
    csr_word_t          badv_q;
    logic [25:0]        eentry_va_q;
    logic [num_int-1:0] int_status;
    csr_word_t          ecfg_wr;
    csr_view_u          estat_view;
    csr_view_u          estat_wr;
    csr_view_u          eentry_view;
    csr_view_u          eentry_wr;

    ////////////////////////////////////////
    // register images

    // bits 10..12 stay low, no timer or ipi source here
    assign int_status = {{(num_int - num_hw_int - 2){1'b0}}, hardware_int, sw_int_q};

    always_comb begin
        estat_view.raw            = '0;
        estat_view.estat.is       = int_status;
        estat_view.estat.ecode    = ecode_q;
        estat_view.estat.esubcode = esubcode_q;
        eentry_view.raw           = '0;
        eentry_view.eentry.va     = eentry_va_q;
    end

    always_comb begin
        ecfg_wr       = merge_word(ecfg_word, wmask, wdata);
        estat_wr.raw  = merge_word(estat_view.raw, wmask, wdata);
        eentry_wr.raw = merge_word(eentry_view.raw, wmask, wdata);
    end

    ////////////////////////////////////////
    // registers

    always_ff @(posedge clk) begin
        if (!rstn) begin
            ecfg_q      <= '0;
            eentry_va_q <= '0;
        end else if (software_we) begin
            if (waddr == addr_ecfg) begin
                ecfg_q <= ecfg_wr[num_int-1:0];
            end
            if (waddr == addr_eentry) begin
                eentry_va_q <= eentry_wr.eentry.va;
            end
        end
    end

    always_ff @(posedge clk) begin
        if (!rstn) begin
            sw_int_q   <= '0;
            ecode_q    <= '0;
            esubcode_q <= '0;
        end else if (ecode_we) begin
            ecode_q    <= ecode_in[ecode_w-1:0];
            // subcode only means something with a nonzero ecode
            esubcode_q <= (ecode_in[ecode_w-1:0] == '0) ? '0 : 9'(ecode_in[ecode_w]);
        end else if (software_we && (waddr == addr_estat)) begin
            // only the two software interrupt bits are writable
            sw_int_q <= estat_wr.estat.is[1:0];
        end
    end

    always_ff @(posedge clk) begin
        if (!rstn) begin
            era_q <= '0;
        end else if (era_we) begin
            era_q <= era_in;
        end else if (software_we && (waddr == addr_era)) begin
            era_q <= merge_word(era_q, wmask, wdata);
        end
    end

    always_ff @(posedge clk) begin
        if (!rstn) begin
            badv_q <= '0;
        end else if (badv_we) begin
            badv_q <= badv_in;
        end else if (software_we && (waddr == addr_badv)) begin
            badv_q <= merge_word(badv_q, wmask, wdata);
        end
    end

    ////////////////////////////////////////
    // outputs

    assign ecfg_word   = csr_word_t'(ecfg_q);
    assign estat_word  = estat_view.raw;
    assign era_word    = era_q;
    assign badv_word   = badv_q;
    assign eentry_word = eentry_view.raw;
    assign ecode       = ecode_q;
    assign era_out     = era_q;
    assign eentry      = eentry_view.raw;

    // idle wakes on any pending line, enabled or not
    assign has_interrupt_idle = |int_status;
    assign has_interrupt_cpu  = ie && (|(int_status & ecfg_q));

endmodule

// File: source/csr_save_regs.sv
`timescale 1ns/10ps

module csr_save_regs (
    input  logic                                                 clk,
    input  logic                                                 rstn,
    input  logic                                                 software_we,
    input  logic [csr_addr_pkg::csr_addr_w-1:0]                  waddr,
    input  csr_field_pkg::csr_word_t                             wmask,
    input  csr_field_pkg::csr_word_t                             wdata,
    output csr_field_pkg::csr_word_t [csr_addr_pkg::num_save-1:0] save_words
);

    import csr_addr_pkg::*;
    import csr_field_pkg::*;

    // one scratch word per consecutive address
    for (genvar i = 0; i < num_save; i++) begin : g_save
        localparam logic [csr_addr_w-1:0] my_addr = addr_save_base + csr_addr_w'(i);

        csr_word_t save_q;

        always_ff @(posedge clk) begin
            if (!rstn) begin
                save_q <= '0;
            end else if (software_we && (waddr == my_addr)) begin
                save_q <= merge_word(save_q, wmask, wdata);
            end
        end

        assign save_words[i] = save_q;
    end

endmodule

// File: source/csr_read_mux.sv
`timescale 1ns/10ps

module csr_read_mux (
    input  logic [csr_addr_pkg::csr_addr_w-1:0]                  raddr,
    input  csr_field_pkg::csr_word_t                             crmd_word,
    input  csr_field_pkg::csr_word_t                             prmd_word,
    input  csr_field_pkg::csr_word_t                             ecfg_word,
    input  csr_field_pkg::csr_word_t                             estat_word,
    input  csr_field_pkg::csr_word_t                             era_word,
    input  csr_field_pkg::csr_word_t                             badv_word,
    input  csr_field_pkg::csr_word_t                             eentry_word,
    input  csr_field_pkg::csr_word_t [csr_addr_pkg::num_save-1:0] save_words,
    output csr_field_pkg::csr_word_t                             rdata
);

    import csr_addr_pkg::*;

    always_comb begin
        // unmapped addresses read as zero
        rdata = '0;
        case (raddr)
            addr_crmd:   rdata = crmd_word;
            addr_prmd:   rdata = prmd_word;
            addr_ecfg:   rdata = ecfg_word;
            addr_estat:  rdata = estat_word;
            addr_era:    rdata = era_word;
            addr_badv:   rdata = badv_word;
            addr_eentry: rdata = eentry_word;
            default: begin
                for (int i = 0; i < num_save; i++) begin
                    if (raddr == addr_save_base + csr_addr_w'(i)) begin
                        rdata = save_words[i];
                    end
                end
            end
        endcase
    end

endmodule

// File: source/csr_top.sv
`timescale 1ns/10ps

module csr_top (
    input  logic                                clk,
    input  logic                                rstn,
    input  logic                                software_we,
    input  logic [csr_addr_pkg::csr_addr_w-1:0] raddr,
    input  logic [csr_addr_pkg::csr_addr_w-1:0] waddr,
    input  csr_field_pkg::csr_word_t            wmask,
    input  csr_field_pkg::csr_word_t            wdata,
    output csr_field_pkg::csr_word_t            rdata,
    input  logic                                store_state,
    input  logic                                restore_state,
    input  logic                                ecode_we,
    input  logic [csr_addr_pkg::ecode_in_w-1:0] ecode_in,
    input  logic                                era_we,
    input  csr_field_pkg::csr_word_t            era_in,
    input  logic                                badv_we,
    input  csr_field_pkg::csr_word_t            badv_in,
    input  logic [csr_addr_pkg::num_hw_int-1:0] hardware_int,
    output csr_field_pkg::plv_t                 plv,
    output logic [csr_addr_pkg::ecode_w-1:0]    ecode,
    output csr_field_pkg::csr_word_t            era_out,
    output csr_field_pkg::csr_word_t            eentry,
    output logic                                has_interrupt_cpu,
    output logic                                has_interrupt_idle,
    output logic [1:0]                          translate_mode,
    output csr_field_pkg::mat_t                 direct_i_mat,
    output csr_field_pkg::mat_t                 direct_d_mat
);

    import csr_addr_pkg::*;
    import csr_field_pkg::*;

    csr_word_t                crmd_word;
    csr_word_t                prmd_word;
    csr_word_t                ecfg_word;
    csr_word_t                estat_word;
    csr_word_t                era_word;
    csr_word_t                badv_word;
    csr_word_t                eentry_word;
    csr_word_t [num_save-1:0] save_words;
    logic                     ie;

    ////////////////////////////////////////
    // register groups

    csr_mode_regs i_mode_regs (
        .clk, .rstn, .software_we, .waddr, .wmask, .wdata,
        .store_state, .restore_state,
        .crmd_word, .prmd_word, .plv, .ie,
        .translate_mode, .direct_i_mat, .direct_d_mat
    );

    csr_exception_regs i_exception_regs (
        .clk, .rstn, .software_we, .waddr, .wmask, .wdata,
        .ecode_we, .ecode_in, .era_we, .era_in, .badv_we, .badv_in,
        .hardware_int, .ie,
        .ecfg_word, .estat_word, .era_word, .badv_word, .eentry_word,
        .ecode, .era_out, .eentry, .has_interrupt_cpu, .has_interrupt_idle
    );

    csr_save_regs i_save_regs (
        .clk, .rstn, .software_we, .waddr, .wmask, .wdata,
        .save_words
    );

    // read side
    csr_read_mux i_read_mux (
        .raddr, .crmd_word, .prmd_word, .ecfg_word, .estat_word,
        .era_word, .badv_word, .eentry_word, .save_words, .rdata
    );

endmodule

// File: dv/csr_tb.sv
`timescale 1ns/10ps

module csr_tb;

    import csr_addr_pkg::*;
    import csr_field_pkg::*;

    localparam int max_steps    = 256;
    localparam int clk_period   = 20;
    localparam int reset_cycles = 10;

    // operation codes in the stimulus file
    localparam logic [7:0] op_end      = 8'h00;
    localparam logic [7:0] op_write    = 8'h01;
    localparam logic [7:0] op_read     = 8'h02;
    localparam logic [7:0] op_store    = 8'h03;
    localparam logic [7:0] op_restore  = 8'h04;
    localparam logic [7:0] op_ecode    = 8'h05;
    localparam logic [7:0] op_hw_write = 8'h06;
    localparam logic [7:0] op_out      = 8'h07;
    localparam logic [7:0] op_mark     = 8'h08;

    logic                  clk = 1'b0;
    logic                  rstn;
    logic                  software_we;
    logic [csr_addr_w-1:0] raddr;
    logic [csr_addr_w-1:0] waddr;
    csr_word_t             wmask;
    csr_word_t             wdata;
    csr_word_t             rdata;
    logic                  store_state;
    logic                  restore_state;
    logic                  ecode_we;
    logic [ecode_in_w-1:0] ecode_in;
    logic                  era_we;
    csr_word_t             era_in;
    logic                  badv_we;
    csr_word_t             badv_in;
    logic [num_hw_int-1:0] hardware_int;
    plv_t                  plv;
    logic [ecode_w-1:0]    ecode;
    csr_word_t             era_out;
    csr_word_t             eentry;
    logic                  has_interrupt_cpu;
    logic                  has_interrupt_idle;
    logic [1:0]            translate_mode;
    mat_t                  direct_i_mat;
    mat_t                  direct_d_mat;

    logic [127:0] stim_mem [max_steps];
    int           num_steps   = 0;
    int           pass_count  = 0;
    int           fail_count  = 0;
    int           step_fails  = 0;
    logic         stim_loaded = 1'b0;

    csr_top i_csr_top (.*);

    always #(clk_period / 2) clk = ~clk;

    ////////////////////////////////////////
    // helpers

    function automatic string output_name(logic [3:0] sel);
        case (sel)
            4'd0: return "plv";
            4'd1: return "translate_mode";
            4'd2: return "ecode";
            4'd3: return "era_out";
            4'd4: return "eentry";
            4'd5: return "has_interrupt_idle";
            4'd6: return "has_interrupt_cpu";
            4'd7: return "direct_i_mat";
            default: return "direct_d_mat";
        endcase
    endfunction

    function automatic csr_word_t output_value(logic [3:0] sel);
        case (sel)
            4'd0: return csr_word_t'(plv);
            4'd1: return csr_word_t'(translate_mode);
            4'd2: return csr_word_t'(ecode);
            4'd3: return era_out;
            4'd4: return eentry;
            4'd5: return csr_word_t'(has_interrupt_idle);
            4'd6: return csr_word_t'(has_interrupt_cpu);
            4'd7: return csr_word_t'(direct_i_mat);
            default: return csr_word_t'(direct_d_mat);
        endcase
    endfunction

    task automatic check_value(string name, csr_word_t expected, csr_word_t actual);
        assert (actual === expected) begin
            pass_count++;
        end else begin
            fail_count++;
            step_fails++;
            $display("Error at %0t ns: %s expected %h, got %h", $time, name, expected, actual);
        end
    endtask

    task automatic clear_strobes();
        software_we   = 1'b0;
        store_state   = 1'b0;
        restore_state = 1'b0;
        ecode_we      = 1'b0;
        era_we        = 1'b0;
        badv_we       = 1'b0;
    endtask

    ////////////////////////////////////////
    // stimulus and checks

    initial begin
        logic [7:0]  op;
        logic [15:0] addr;
        csr_word_t   mask;
        csr_word_t   data;
        logic [7:0]  hw;
        csr_word_t   expv;

        rstn         = 1'b0;
        raddr        = '0;
        waddr        = '0;
        wmask        = '0;
        wdata        = '0;
        ecode_in     = '0;
        era_in       = '0;
        badv_in      = '0;
        hardware_int = '0;
        clear_strobes();

        foreach (stim_mem[i]) stim_mem[i] = '0;
        $readmemh("dv/csr_stim.mem", stim_mem);
        while (num_steps < max_steps && stim_mem[num_steps][127:120] != op_end) begin
            num_steps++;
        end
        stim_loaded = 1'b1;
        if (num_steps == 0) begin
            fail_count++;
            $display("no stimulus steps were loaded from dv/csr_stim.mem");
        end

        repeat (reset_cycles) @(posedge clk);
        #2;
        rstn = 1'b1;

        for (int s = 0; s < num_steps; s++) begin
            {op, addr, mask, data, hw, expv} = stim_mem[s];
            @(posedge clk);
            #2;
            clear_strobes();
            hardware_int = hw;
            case (op)
                op_write: begin
                    software_we = 1'b1;
                    waddr       = addr[csr_addr_w-1:0];
                    wmask       = mask;
                    wdata       = data;
                end
                op_read: begin
                    raddr = addr[csr_addr_w-1:0];
                    #8;
                    check_value("rdata", expv, rdata);
                end
                op_store:   store_state   = 1'b1;
                op_restore: restore_state = 1'b1;
                op_ecode: begin
                    ecode_we = 1'b1;
                    ecode_in = data[ecode_in_w-1:0];
                end
                op_hw_write: begin
                    // hardware and software hit the same register in one cycle
                    software_we = 1'b1;
                    waddr       = addr[csr_addr_w-1:0];
                    wmask       = mask;
                    wdata       = data;
                    era_we      = (addr[csr_addr_w-1:0] == addr_era);
                    badv_we     = (addr[csr_addr_w-1:0] == addr_badv);
                    era_in      = expv;
                    badv_in     = expv;
                end
                op_out: begin
                    #8;
                    check_value(output_name(addr[3:0]), expv, output_value(addr[3:0]));
                end
                op_mark: begin
                    $display("behavior %0d finished with %0d errors", addr, step_fails);
                    step_fails = 0;
                end
                default: begin
                    fail_count++;
                    $display("unknown operation %h in stimulus step %0d", op, s);
                end
            endcase
        end
        @(posedge clk);
        #2;
        clear_strobes();

        $display("checks passed %0d, failed %0d", pass_count, fail_count);
        if (fail_count == 0) begin
            $display("TB PASSED");
        end else begin
            $display("TB FAILED");
        end
        $finish;
    end

    // watchdog, sized from the step count
    initial begin
        wait (stim_loaded);
        #(num_steps * 4 * clk_period + reset_cycles * clk_period);
        $display("timeout: the run did not finish within the expected time");
        $display("TB FAILED");
        $finish;
    end

endmodule

// File: dv/csr_stim.mem
// columns: op(2) addr(4) mask(8) data(8) hardware_int(2) expected(8)
// op 01 write 02 read 03 store 04 restore 05 ecode 06 hw write 07 output 08 end of behavior
02_0000_00000000_00000000_00_00000008
02_0005_00000000_00000000_00_00000000
07_0001_00000000_00000000_00_00000001
07_0005_00000000_00000000_00_00000000
08_0001_00000000_00000000_00_00000000
01_0031_0000ffff_12345678_00_00000000
02_0031_00000000_00000000_00_00005678
01_0033_ffff0000_87654321_00_00000000
02_0033_00000000_00000000_00_87650000
01_0006_ff00ff00_11223344_00_00000000
07_0003_00000000_00000000_00_11003300
01_000c_ffffffff_abcdefff_00_00000000
02_000c_00000000_00000000_00_abcdefc0
07_0004_00000000_00000000_00_abcdefc0
02_0020_00000000_00000000_00_00000000
08_0002_00000000_00000000_00_00000000
01_0000_00000018_00000018_00_00000000
01_0000_00000018_00000000_00_00000000
02_0000_00000000_00000000_00_00000008
01_0000_00000018_00000010_00_00000000
07_0001_00000000_00000000_00_00000002
01_0000_000001e7_000001a7_00_00000000
02_0000_00000000_00000000_00_000001b7
08_0003_00000000_00000000_00_00000000
03_0000_00000000_00000000_00_00000000
02_0001_00000000_00000000_00_00000007
02_0000_00000000_00000000_00_000001b0
01_0001_ffffffff_00000006_00_00000000
04_0000_00000000_00000000_00_00000000
02_0000_00000000_00000000_00_000001b6
08_0004_00000000_00000000_00_00000000
05_0000_00000000_0000004d_00_00000000
02_0005_00000000_00000000_00_004d0000
07_0002_00000000_00000000_00_0000000d
05_0000_00000000_00000040_00_00000000
02_0005_00000000_00000000_00_00000000
06_0006_ffffffff_55555555_00_1c000100
07_0003_00000000_00000000_00_1c000100
06_0007_ffffffff_00000000_00_deadbeef
02_0007_00000000_00000000_00_deadbeef
01_0007_0000ffff_00001234_00_00000000
02_0007_00000000_00000000_00_dead1234
08_0005_00000000_00000000_00_00000000
07_0005_00000000_00000000_04_00000001
07_0006_00000000_00000000_04_00000000
01_0004_ffffffff_00000010_00_00000000
07_0006_00000000_00000000_04_00000001
01_0005_00000003_00000001_00_00000000
07_0005_00000000_00000000_00_00000001
02_0005_00000000_00000000_00_00000001
03_0000_00000000_00000000_00_00000000
07_0006_00000000_00000000_04_00000000
08_0006_00000000_00000000_00_00000000
00_0000_00000000_00000000_00_00000000

// File: flist.f
source/csr_addr_pkg.sv
source/csr_field_pkg.sv
source/csr_mode_regs.sv
source/csr_exception_regs.sv
source/csr_save_regs.sv
source/csr_read_mux.sv
source/csr_top.sv
dv/csr_tb.sv

// File: Makefile
VERILATOR ?= verilator
VFLAGS    ?= --binary --timing --assert -j 0
TOP       := csr_tb
FLIST     := flist.f
BUILD_DIR := obj_dir
SIM_BIN   := $(BUILD_DIR)/V$(TOP)
LOG       := sim.log

SOURCES := $(filter %.sv %.v,$(shell cat $(FLIST)))

.PHONY: all run clean

all: run

$(SIM_BIN): $(FLIST) $(SOURCES)
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) --Mdir $(BUILD_DIR) -f $(FLIST)

run: $(SIM_BIN) dv/csr_stim.mem
	$(SIM_BIN) | tee $(LOG)
	@grep -q "TB PASSED" $(LOG) || { echo "simulation failed, see $(LOG)"; exit 1; }

clean:
	rm -rf $(BUILD_DIR) $(LOG)
